//--- fpu_out.f
+incdir+.
fpu_out_pkg.sv
fpu_out_add_fmt.sv
fpu_out_fp_fmt.sv
fpu_out_ctl.sv
fpu_out_dp.sv
fpu_out.sv
tb_fpu_out.sv

//--- fpu_out.sv
//////////////////////////////////////////////////////////////////////
// fpu result output stage top, three pipes into one cpx packet
// pipes hold their result level while their hold output is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fpu_out_cfg.svh"

module fpu_out (
	input  logic			rclk,
	input  logic			rst_n,
	input  fpu_out_pkg::add_res_t	add_res,	// add pipe, index 0
	input  fpu_out_pkg::fp_res_t	mul_res,	// mul pipe, index 1
	input  fpu_out_pkg::fp_res_t	div_res,	// div pipe, index 2
	output logic			hold_add,
	output logic			hold_mul,
	output logic			hold_div,
	output fpu_out_pkg::cpx_pkt_t	cpx_pkt
);

	fpu_out_pkg::fmt_res_t		add_fmt;
	fpu_out_pkg::fmt_res_t		mul_fmt;
	fpu_out_pkg::fmt_res_t		div_fmt;
	logic [`FPU_OUT_NPIPE-1:0]	req;	// vld bits in pipe order
	logic [`FPU_OUT_NPIPE-1:0]	grant;
	logic [`FPU_OUT_NPIPE-1:0]	hold;

	assign req      = {div_res.vld, mul_res.vld, add_res.vld};
	assign hold_add = hold[0];
	assign hold_mul = hold[1];
	assign hold_div = hold[2];

	//////////////////////////////////////////////////////////////////////
	// formatters

	fpu_out_add_fmt add_fmt_inst (.add_res(add_res), .fmt(add_fmt));
	fpu_out_fp_fmt  mul_fmt_inst (.res(mul_res), .fmt(mul_fmt));
	fpu_out_fp_fmt  div_fmt_inst (.res(div_res), .fmt(div_fmt));

	// arbiter and output register
	fpu_out_ctl ctl_inst (
		.rclk	(rclk),
		.rst_n	(rst_n),
		.req	(req),
		.grant	(grant),
		.hold	(hold)
	);

	fpu_out_dp dp_inst (
		.rclk		(rclk),
		.rst_n		(rst_n),
		.add_fmt	(add_fmt),
		.mul_fmt	(mul_fmt),
		.div_fmt	(div_fmt),
		.grant		(grant),
		.cpx_pkt	(cpx_pkt)
	);

endmodule

//--- fpu_out_add_fmt.sv
//////////////////////////////////////////////////////////////////////
// add pipe result formatter, purely combinational
// frac is 64 bits wide, float fractions sit below its top bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_out_add_fmt (
	input  fpu_out_pkg::add_res_t	add_res,	// add pipe level
	output fpu_out_pkg::fmt_res_t	fmt		// formatted word and flags
);

	logic [63:0]	data;	// data word by destination format

	//////////////////////////////////////////////////////////////////////
	// data word

	always_comb begin
		data = '0;
		case (add_res.dst)
			fpu_out_pkg::DBL: begin
				data = {add_res.sign, add_res.exp, add_res.frac[62:11]};
			end
			fpu_out_pkg::SNG: begin
				// single is left aligned, low word zero
				data = {add_res.sign, add_res.exp[7:0],
					add_res.frac[62:40], 32'b0};
			end
			fpu_out_pkg::LONG: begin
				data = add_res.frac;		// 64 bit integer as is
			end
			fpu_out_pkg::INT: begin
				data = {add_res.frac[63:32], 32'b0};	// int in high word
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// formatted result

	always_comb begin
		fmt.thr  = add_res.thr;
		fmt.exc  = add_res.exc;
		// compare and cc bits land in packet bits 71:64
		fmt.aux  = {2'b0, add_res.fcmp, add_res.cc, add_res.fcc, 1'b0};
		fmt.data = data;
	end

endmodule

//--- fpu_out_cfg.svh
//////////////////////////////////////////////////////////////////////
// build constants for the fpu result output stage
// pipe order is fixed: add 0, mul 1, div 2
//////////////////////////////////////////////////////////////////////

`ifndef FPU_OUT_CFG_SVH
`define FPU_OUT_CFG_SVH

// thread tag carried with every result
// the 145 bit cpx layout only holds for a 2 bit tag
`define FPU_OUT_THR_W	2

// cpx return type for fpu results
`define FPU_OUT_RTYPE	4'b1000

// number of result pipes feeding the arbiter
`define FPU_OUT_NPIPE	3

`endif

//--- fpu_out_ctl.sv
//////////////////////////////////////////////////////////////////////
// round robin result arbiter, at most one grant per cycle
// grant and hold are combinational from req and last grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fpu_out_cfg.svh"

module fpu_out_ctl (
	input  logic				rclk,
	input  logic				rst_n,
	input  logic [`FPU_OUT_NPIPE-1:0]	req,	// pipe vld bits
	output logic [`FPU_OUT_NPIPE-1:0]	grant,	// one hot winner
	output logic [`FPU_OUT_NPIPE-1:0]	hold	// losers keep their result
);

	localparam int IDX_W = $clog2(`FPU_OUT_NPIPE);

	logic [IDX_W-1:0]	last_idx;	// pipe granted most recently
	logic [IDX_W-1:0]	gnt_idx;	// pipe granted this cycle
	logic			found;		// search already has a winner

	//////////////////////////////////////////////////////////////////////
	// search from the pipe after the last winner, wrapping round

	always_comb begin
		int idx;
		grant   = '0;
		gnt_idx = last_idx;
		found   = 1'b0;
		for (int i = 1; i <= `FPU_OUT_NPIPE; i++) begin
			idx = (int'(last_idx) + i) % `FPU_OUT_NPIPE;
			if (req[idx] && !found) begin
				grant[idx] = 1'b1;
				gnt_idx    = IDX_W'(idx);
				found      = 1'b1;
			end
		end
	end

	assign hold = req & ~grant;	// idle pipes see hold low

	//////////////////////////////////////////////////////////////////////
	// last grant state

	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			last_idx <= IDX_W'(`FPU_OUT_NPIPE - 1);	// div, so add wins first
		end else if (found) begin
			last_idx <= gnt_idx;
		end
	end

endmodule

//--- fpu_out_dp.sv
//////////////////////////////////////////////////////////////////////
// output datapath, and-or select of the granted result
// packet is registered once, cpx side never stalls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fpu_out_cfg.svh"

module fpu_out_dp (
	input  logic				rclk,
	input  logic				rst_n,
	input  fpu_out_pkg::fmt_res_t		add_fmt,
	input  fpu_out_pkg::fmt_res_t		mul_fmt,
	input  fpu_out_pkg::fmt_res_t		div_fmt,
	input  logic [`FPU_OUT_NPIPE-1:0]	grant,	// one hot from ctl
	output fpu_out_pkg::cpx_pkt_t		cpx_pkt	// ca stage packet
);

	localparam int FMT_W = $bits(fpu_out_pkg::fmt_res_t);

	fpu_out_pkg::fmt_res_t	sel;		// granted result, zero when idle
	fpu_out_pkg::cpx_pkt_t	pkt_nxt;	// packet into the ca register
	logic			any_gnt;

	assign any_gnt = |grant;

	//////////////////////////////////////////////////////////////////////
	// result select

	assign sel = ({FMT_W{grant[0]}} & add_fmt)
		| ({FMT_W{grant[1]}} & mul_fmt)
		| ({FMT_W{grant[2]}} & div_fmt);

	//////////////////////////////////////////////////////////////////////
	// packet build, header bits gated by any grant

	always_comb begin
		pkt_nxt       = '0;		// reserved fields stay zero
		pkt_nxt.vld   = any_gnt;
		pkt_nxt.rtype = any_gnt ? `FPU_OUT_RTYPE : 4'b0;
		pkt_nxt.thr   = sel.thr;
		pkt_nxt.exc   = sel.exc;
		pkt_nxt.aux   = sel.aux;
		pkt_nxt.data  = sel.data;
	end

	// ca stage register
	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			cpx_pkt <= '0;
		end else begin
			cpx_pkt <= pkt_nxt;	// idle cycles load an all zero packet
		end
	end

endmodule

//--- fpu_out_fp_fmt.sv
//////////////////////////////////////////////////////////////////////
// multiply or divide result formatter, one copy per pipe
// single results keep exponent bits 7:0 only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_out_fp_fmt (
	input  fpu_out_pkg::fp_res_t	res,	// mul or div pipe level
	output fpu_out_pkg::fmt_res_t	fmt
);

	logic [63:0]	dbl_word;	// double layout
	logic [63:0]	sng_word;	// single layout, low word zero

	assign dbl_word = {res.sign, res.exp, res.frac};
	assign sng_word = {res.sign, res.exp[7:0], res.frac[51:29], 32'b0};

	always_comb begin
		fmt.thr  = res.thr;
		fmt.exc  = res.exc;
		fmt.aux  = '0;					// no compare bits here
		fmt.data = res.dbl ? dbl_word : sng_word;	// pick by precision
	end

endmodule

//--- fpu_out_pkg.sv
//////////////////////////////////////////////////////////////////////
// result and packet types for the fpu output stage
// cpx packet is 145 bits and assumes a 2 bit thread tag
//////////////////////////////////////////////////////////////////////

`include "fpu_out_cfg.svh"

package fpu_out_pkg;

	// destination format of an add pipe result
	typedef enum logic [1:0] {
		DBL  = 2'd0,	// double float
		SNG  = 2'd1,	// single float
		LONG = 2'd2,	// 64 bit integer
		INT  = 2'd3	// 32 bit integer
	} add_dst_e;

	// add pipe result, held as a level until hold drops
	typedef struct packed {
		logic				vld;	// result waiting
		logic [`FPU_OUT_THR_W-1:0]	thr;	// thread tag
		add_dst_e			dst;	// destination format
		logic				sign;
		logic [10:0]			exp;
		logic [63:0]			frac;	// 64 bits, covers long results
		logic [4:0]			exc;	// ieee exception flags
		logic				fcmp;	// compare op
		logic [1:0]			cc;	// compare condition code
		logic [1:0]			fcc;	// fcc passed through
	} add_res_t;

	// multiply or divide result
	typedef struct packed {
		logic				vld;
		logic [`FPU_OUT_THR_W-1:0]	thr;
		logic				dbl;	// 1 double, 0 single
		logic				sign;
		logic [10:0]			exp;
		logic [51:0]			frac;
		logic [4:0]			exc;
	} fp_res_t;

	// formatter output, one per pipe
	typedef struct packed {
		logic [`FPU_OUT_THR_W-1:0]	thr;
		logic [4:0]			exc;
		logic [7:0]			aux;	// add compare and cc bits
		logic [63:0]			data;	// cpx data word
	} fmt_res_t;

	// cpx return packet, msb first
	typedef struct packed {
		logic				vld;		// 144
		logic [3:0]			rtype;		// 143:140
		logic [2:0]			rsvd_hi;	// 139:137
		logic				rsvd_mid;	// 136
		logic [`FPU_OUT_THR_W-1:0]	thr;		// 135:134
		logic [56:0]			rsvd_lo;	// 133:77
		logic [4:0]			exc;		// 76:72
		logic [7:0]			aux;		// 71:64
		logic [63:0]			data;		// 63:0
	} cpx_pkt_t;

endpackage

//--- tb_fpu_out_model.svh
//////////////////////////////////////////////////////////////////////
// reference model for the fpu output stage testbench
// included inside the testbench module, uses its lfsr_state
//////////////////////////////////////////////////////////////////////

`ifndef TB_FPU_OUT_MODEL_SVH
`define TB_FPU_OUT_MODEL_SVH

// fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

// n random bits, one lfsr step each
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[62:0], lfsr_bit()};
	return v;
endfunction

// add pipe data word by destination format
function automatic logic [63:0] add_data_ref(input fpu_out_pkg::add_res_t r);
	case (r.dst)
		fpu_out_pkg::DBL: return {r.sign, r.exp, r.frac[62:11]};
		fpu_out_pkg::SNG: return {r.sign, r.exp[7:0], r.frac[62:40], 32'h0};
		fpu_out_pkg::LONG: return r.frac;
		default: return {r.frac[63:32], 32'h0};	// int, left aligned
	endcase
endfunction

// compare and cc bits of an add result
function automatic logic [7:0] add_aux_ref(input fpu_out_pkg::add_res_t r);
	return {2'b00, r.fcmp, r.cc, r.fcc, 1'b0};
endfunction

// mul or div data word, single left aligned
function automatic logic [63:0] fp_data_ref(input fpu_out_pkg::fp_res_t r);
	if (r.dbl)
		return {r.sign, r.exp, r.frac};
	return {r.sign, r.exp[7:0], r.frac[51:29], 32'h0};
endfunction

// expected 145 bit packet, vld rtype rsvd thr rsvd exc aux data
function automatic logic [144:0] pkt_ref(input logic [`FPU_OUT_THR_W-1:0] thr,
	input logic [4:0] exc, input logic [7:0] aux, input logic [63:0] data);
	return {1'b1, `FPU_OUT_RTYPE, 4'h0, thr, 57'h0, exc, aux, data};
endfunction

// round robin winner after last, -1 when nobody asks
function automatic int rr_pick(input int last, input logic [2:0] req);
	int p;
	for (int i = 1; i <= 3; i++) begin
		p = (last + i) % 3;
		if (req[p])
			return p;
	end
	return -1;
endfunction

`endif

//--- tb_fpu_out.sv
//////////////////////////////////////////////////////////////////////
// testbench for the fpu output stage with random traffic from an lfsr
// pipes obey hold and each packet is checked against the model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fpu_out_cfg.svh"

module tb_fpu_out;

	logic			rclk;
	logic			rst_n;
	fpu_out_pkg::add_res_t	add_res;
	fpu_out_pkg::fp_res_t	mul_res;
	fpu_out_pkg::fp_res_t	div_res;
	logic			hold_add;
	logic			hold_mul;
	logic			hold_div;
	fpu_out_pkg::cpx_pkt_t	cpx_pkt;

	logic [15:0]		lfsr_state = 16'd97;	// seed
	fpu_out_pkg::add_res_t	add_nxt;	// next result per pipe when it is free
	fpu_out_pkg::fp_res_t	mul_nxt;
	fpu_out_pkg::fp_res_t	div_nxt;
	logic [2:0]		hold_q;		// holds seen at the last negedge
	int			issued;		// results loaded into the pipes
	int			pkt_cnt;	// packets seen on cpx
	int			errs;
	int			timeouts;
	logic [1:0]		out_thr[$];	// thread tags in output order

	// model state for the compare process
	int			model_last;
	int			win;
	logic [2:0]		req;
	logic [2:0]		exp_hold;
	logic [144:0]		exp_pkt;	// expected on the next negedge
	logic [144:0]		pkt_bits;

	`include "tb_fpu_out_model.svh"

	fpu_out fpu_out_inst (
		.rclk		(rclk),
		.rst_n		(rst_n),
		.add_res	(add_res),
		.mul_res	(mul_res),
		.div_res	(div_res),
		.hold_add	(hold_add),
		.hold_mul	(hold_mul),
		.hold_div	(hold_div),
		.cpx_pkt	(cpx_pkt)
	);

	initial begin
		rclk = 1'b0;
		forever #2 rclk = ~rclk;	// 4 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	function automatic fpu_out_pkg::add_res_t rand_add(input logic [1:0] dst);
		fpu_out_pkg::add_res_t r;
		r.vld  = 1'b1;
		r.thr  = rand_bits(`FPU_OUT_THR_W);
		r.dst  = fpu_out_pkg::add_dst_e'(dst);
		r.sign = rand_bits(1);
		r.exp  = rand_bits(11);
		r.frac = rand_bits(64);
		r.exc  = rand_bits(5);
		r.fcmp = rand_bits(1);
		r.cc   = rand_bits(2);
		r.fcc  = rand_bits(2);
		return r;
	endfunction

	function automatic fpu_out_pkg::fp_res_t rand_fp(input logic dbl);
		fpu_out_pkg::fp_res_t r;
		r.vld  = 1'b1;
		r.thr  = rand_bits(`FPU_OUT_THR_W);
		r.dbl  = dbl;
		r.sign = rand_bits(1);
		r.exp  = rand_bits(11);
		r.frac = rand_bits(52);
		r.exc  = rand_bits(5);
		return r;
	endfunction

	// one stimulus cycle where a held pipe keeps its result
	task automatic drive(input logic [2:0] load);
		@(posedge rclk);
		if (!(add_res.vld && hold_q[0])) begin
			add_res <= load[0] ? add_nxt : '0;
			issued += load[0];
		end
		if (!(mul_res.vld && hold_q[1])) begin
			mul_res <= load[1] ? mul_nxt : '0;
			issued += load[1];
		end
		if (!(div_res.vld && hold_q[2])) begin
			div_res <= load[2] ? div_nxt : '0;
			issued += load[2];
		end
	endtask

	// idle the pipes until every issued result came out
	task automatic drain(input int limit, input string what);
		int n;
		n = 0;
		while (pkt_cnt < issued && n < limit && timeouts == 0) begin
			drive(3'b000);
			n++;
		end
		if (pkt_cnt < issued && timeouts == 0) begin
			timeouts++;
			$display("timeout in %s: only %0d of %0d results came out after %0d cycles",
				what, pkt_cnt, issued, limit);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare process at the falling edge where outputs are stable

	always @(negedge rclk) begin
		if (!rst_n) begin
			model_last = 2;		// last grant at div so add wins first
			exp_pkt    = '0;
			hold_q     = '0;
		end else begin
			pkt_bits = cpx_pkt;
			assert (pkt_bits === exp_pkt) else begin
				errs++;
				$display("Mismatch at %0t: cpx_pkt %h expected %h", $time, pkt_bits, exp_pkt);
			end
			assert (pkt_bits[139:136] == 4'h0 && pkt_bits[133:77] == 57'h0) else begin
				errs++;
				$display("Mismatch at %0t: reserved bits set in %h", $time, pkt_bits);
			end
			if (pkt_bits[144]) begin
				pkt_cnt++;
				out_thr.push_back(pkt_bits[135:134]);
				assert (pkt_bits[143:140] == `FPU_OUT_RTYPE) else begin
					errs++;
					$display("Mismatch at %0t: rtype %b", $time, pkt_bits[143:140]);
				end
			end
			// winner of this cycle and its packet for the next one
			req      = {div_res.vld, mul_res.vld, add_res.vld};
			win      = rr_pick(model_last, req);
			exp_hold = (win < 0) ? req : req & ~(3'b001 << win);
			hold_q   = {hold_div, hold_mul, hold_add};
			assert (hold_q === exp_hold) else begin
				errs++;
				$display("Mismatch at %0t: hold %b expected %b", $time, hold_q, exp_hold);
			end
			case (win)
				0: exp_pkt = pkt_ref(add_res.thr, add_res.exc, add_aux_ref(add_res),
					add_data_ref(add_res));
				1: exp_pkt = pkt_ref(mul_res.thr, mul_res.exc, 8'h0, fp_data_ref(mul_res));
				2: exp_pkt = pkt_ref(div_res.thr, div_res.exc, 8'h0, fp_data_ref(div_res));
				default: exp_pkt = '0;	// idle cycle gives an all zero packet
			endcase
			if (win >= 0)
				model_last = win;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		int base;
		rst_n    = 1'b0;
		add_res  = '0;
		mul_res  = '0;
		div_res  = '0;
		add_nxt  = '0;
		mul_nxt  = '0;
		div_nxt  = '0;
		issued   = 0;
		pkt_cnt  = 0;
		errs     = 0;
		timeouts = 0;
		repeat (2) @(posedge rclk);
		rst_n <= 1'b1;

		// idle after reset gives no packet
		repeat (6) drive(3'b000);
		assert (pkt_cnt == 0) else begin
			errs++;
			$display("Mismatch at %0t: %0d packets with no valid pipe", $time, pkt_cnt);
		end

		// lone add results in DBL SNG LONG and INT
		for (int d = 0; d < 4; d++) begin
			add_nxt = rand_add(2'(d));
			drive(3'b001);
			drain(20, "lone add");
		end

		// lone mul then div in single and double so div is granted last
		for (int k = 0; k < 4; k++) begin
			if (k < 2) begin
				mul_nxt = rand_fp(k[0]);
				drive(3'b010);
			end else begin
				div_nxt = rand_fp(k[0]);
				drive(3'b100);
			end
			drain(20, "lone mul/div");
		end

		// all pipes busy with the pipe index in the tag
		out_thr.delete();
		base = issued;
		for (int c = 0; c < 12; c++) begin
			add_nxt     = rand_add(rand_bits(2));
			add_nxt.thr = 2'd0;
			mul_nxt     = rand_fp(rand_bits(1));
			mul_nxt.thr = 2'd1;
			div_nxt     = rand_fp(rand_bits(1));
			div_nxt.thr = 2'd2;
			drive(3'b111);
		end
		drain(20, "all pipes valid");
		assert (out_thr.size() == issued - base) else begin
			errs++;
			$display("Mismatch at %0t: %0d packets with all pipes valid, expected %0d",
				$time, out_thr.size(), issued - base);
		end
		for (int i = 0; i < out_thr.size(); i++) begin
			assert (out_thr[i] == 2'(i % 3)) else begin
				errs++;
				$display("Mismatch at %0t: packet %0d from pipe %0d, expected %0d",
					$time, i, out_thr[i], i % 3);
			end
		end

		// long random traffic
		for (int c = 0; c < 600; c++) begin
			add_nxt = rand_add(rand_bits(2));
			mul_nxt = rand_fp(rand_bits(1));
			div_nxt = rand_fp(rand_bits(1));
			drive(rand_bits(3));
		end
		drain(50, "random traffic");
		drive(3'b000);		// let a stray extra packet show up
		drive(3'b000);
		assert (pkt_cnt == issued) else begin
			errs++;
			$display("Mismatch at %0t: %0d packets for %0d results, lost or duplicated",
				$time, pkt_cnt, issued);
		end

		$display("errors: %0d mismatches, %0d timeouts, %0d packets checked",
			errs, timeouts, pkt_cnt);
		if (errs == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
